// File: debug_mon_pkg.sv
package debug_mon_pkg;

  // --------------------------------------------------
  // Widths and PC increments
  // --------------------------------------------------
  localparam int XLEN = 32;

  // Byte distance to the next instruction
  localparam logic [XLEN-1:0] PC_INC_RVC = 32'd2;
  localparam logic [XLEN-1:0] PC_INC_RVI = 32'd4;

  // --------------------------------------------------
  // Instruction encodings
  // --------------------------------------------------
  localparam logic [XLEN-1:0] EBREAK_INSN  = 32'h0010_0073;
  localparam logic [XLEN-1:0] WFI_INSN     = 32'h1050_0073;
  localparam logic [XLEN-1:0] DRET_INSN    = 32'h7b20_0073;

  // Compressed form, only the low half-word is meaningful
  localparam logic [15:0]     CEBREAK_INSN = 16'h9002;

  // --------------------------------------------------
  // Debug cause, same encoding as dcsr.cause
  // --------------------------------------------------
  typedef enum logic [2:0] {
    CAUSE_NONE    = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_TRIGGER = 3'd2,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } dbg_cause_t;

  // --------------------------------------------------
  // Packed structs
  // --------------------------------------------------

  // One retirement from writeback
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] insn;
  } retire_t;

  // Quasi-static debug configuration
  typedef struct packed {
    logic            ebreakm;
    logic            step;
    logic            trig_en;
    logic [XLEN-1:0] tdata2;
    logic [XLEN-1:0] halt_addr;
    logic [XLEN-1:0] boot_addr;
  } dbg_cfg_t;

  // Per-cycle result of the classifier stage
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic            is_ebreak;
    logic            is_wfi;
    logic            is_dret;
    logic            addr_match;
    logic            halt_req;
    logic            irq_pending;
  } cycle_info_t;

  // One debug-mode entry
  typedef struct packed {
    dbg_cause_t      cause;
    logic [XLEN-1:0] dpc;
    logic [XLEN-1:0] handler_pc;
  } dbg_entry_t;

endpackage

// File: insn_classifier.sv
`timescale 1ns/1ps

module insn_classifier (
  input  logic                           cov_assert_if,
  input  logic                           rst_n_i,
  input  debug_mon_pkg::retire_t         retire_i,
  input  logic                           debug_req_i,
  input  logic [debug_mon_pkg::XLEN-1:0] irq_i,
  input  logic [debug_mon_pkg::XLEN-1:0] mie_i,
  input  debug_mon_pkg::dbg_cfg_t        cfg_i,
  output debug_mon_pkg::cycle_info_t     info_o
);

  logic                       is_compressed;
  logic                       match_ebreak;
  logic                       match_cebreak;
  logic                       match_wfi;
  logic                       match_dret;
  logic                       match_tdata2;
  debug_mon_pkg::cycle_info_t info_d;
  debug_mon_pkg::cycle_info_t info_q;

  // --------------------------------------------------
  // Decode of the retired word
  // --------------------------------------------------

  // Low two bits other than 2'b11 mark a 16-bit instruction
  assign is_compressed = (retire_i.insn[1:0] != 2'b11);

  assign match_ebreak  = (retire_i.insn == debug_mon_pkg::EBREAK_INSN);
  assign match_cebreak = is_compressed &&
                         (retire_i.insn[15:0] == debug_mon_pkg::CEBREAK_INSN);
  assign match_wfi     = (retire_i.insn == debug_mon_pkg::WFI_INSN);
  assign match_dret    = (retire_i.insn == debug_mon_pkg::DRET_INSN);

  // Execute address trigger on the retiring pc
  assign match_tdata2  = (retire_i.pc == cfg_i.tdata2);

  // --------------------------------------------------
  // Next-state of the stage register
  // --------------------------------------------------
  always_comb begin
    info_d.valid   = retire_i.valid;
    info_d.pc      = retire_i.pc;
    info_d.next_pc = retire_i.pc + (is_compressed ? debug_mon_pkg::PC_INC_RVC
                                                  : debug_mon_pkg::PC_INC_RVI);

    // Instruction flags only count for a real retirement
    info_d.is_ebreak  = retire_i.valid && (match_ebreak || match_cebreak);
    info_d.is_wfi     = retire_i.valid && match_wfi;
    info_d.is_dret    = retire_i.valid && match_dret;
    info_d.addr_match = retire_i.valid && cfg_i.trig_en && match_tdata2;

    // Request lines are sampled every cycle
    info_d.halt_req    = debug_req_i;
    info_d.irq_pending = |(irq_i & mie_i);
  end

  // pc and next_pc ride along without reset, the flags are cleared
  always_ff @(posedge cov_assert_if) begin
    info_q <= info_d;
    if (!rst_n_i) begin
      info_q.valid       <= 1'b0;
      info_q.is_ebreak   <= 1'b0;
      info_q.is_wfi      <= 1'b0;
      info_q.is_dret     <= 1'b0;
      info_q.addr_match  <= 1'b0;
      info_q.halt_req    <= 1'b0;
      info_q.irq_pending <= 1'b0;
    end
  end

  assign info_o = info_q;

endmodule

// File: debug_cause_arbiter.sv
`timescale 1ns/1ps

module debug_cause_arbiter (
  input  logic                           cov_assert_if,
  input  logic                           rst_n_i,
  input  debug_mon_pkg::cycle_info_t     info_i,
  input  debug_mon_pkg::dbg_cfg_t        cfg_i,
  output logic                           entry_valid_o,
  output debug_mon_pkg::dbg_entry_t      entry_o,
  output logic                           exit_valid_o,
  output logic [debug_mon_pkg::XLEN-1:0] resume_pc_o,
  output logic                           illegal_dret_o,
  output logic                           debug_mode_o,
  output logic                           sleep_o
);

  // Mode state
  logic                           debug_mode_q;
  logic                           sleep_q;
  logic                           sleep_d;
  logic [debug_mon_pkg::XLEN-1:0] dpc_q;
  logic [debug_mon_pkg::XLEN-1:0] last_npc_q;

  // Decisions for the current cycle
  debug_mon_pkg::dbg_cause_t      cause;
  logic [debug_mon_pkg::XLEN-1:0] dpc_d;
  logic [debug_mon_pkg::XLEN-1:0] handler_pc;
  logic                           take_entry;
  logic                           take_exit;
  logic                           bad_dret;

  // Output registers
  logic                           entry_valid_q;
  debug_mon_pkg::dbg_entry_t      entry_q;
  logic                           exit_valid_q;
  logic [debug_mon_pkg::XLEN-1:0] resume_pc_q;
  logic                           illegal_dret_q;

  // --------------------------------------------------
  // Cause priority
  // --------------------------------------------------

  // Trigger beats ebreak beats haltreq beats step
  always_comb begin
    cause = debug_mon_pkg::CAUSE_NONE;
    if (!debug_mode_q) begin
      if (info_i.addr_match) begin
        cause = debug_mon_pkg::CAUSE_TRIGGER;
      end else if (info_i.is_ebreak && cfg_i.ebreakm) begin
        cause = debug_mon_pkg::CAUSE_EBREAK;
      end else if (info_i.halt_req) begin
        cause = debug_mon_pkg::CAUSE_HALTREQ;
      end else if (info_i.valid && cfg_i.step) begin
        cause = debug_mon_pkg::CAUSE_STEP;
      end
    end
  end

  // --------------------------------------------------
  // Debug PC
  // --------------------------------------------------
  always_comb begin
    case (cause)
      // Trigger and ebreak do not complete, resume re-executes them
      debug_mon_pkg::CAUSE_TRIGGER,
      debug_mon_pkg::CAUSE_EBREAK: begin
        dpc_d = info_i.pc;
      end
      debug_mon_pkg::CAUSE_HALTREQ: begin
        // No retire this cycle means the core halts where it left off
        dpc_d = info_i.valid ? info_i.next_pc : last_npc_q;
      end
      debug_mon_pkg::CAUSE_STEP: begin
        dpc_d = info_i.next_pc;
      end
      default: begin
        dpc_d = last_npc_q;
      end
    endcase
  end

  // Handler entry is word aligned
  assign handler_pc = {cfg_i.halt_addr[debug_mon_pkg::XLEN-1:2], 2'b00};

  assign take_entry = (cause != debug_mon_pkg::CAUSE_NONE);
  assign take_exit  = debug_mode_q && info_i.is_dret;

  // A stepped dret enters debug mode instead of trapping
  assign bad_dret   = !debug_mode_q && info_i.is_dret && !take_entry;

  // --------------------------------------------------
  // WFI sleep
  // --------------------------------------------------
  always_comb begin
    sleep_d = sleep_q;
    if (info_i.is_wfi && !debug_mode_q && !info_i.halt_req && !cfg_i.step) begin
      sleep_d = 1'b1;
    end
    // Wake-up wins over a WFI in the same cycle
    if (info_i.irq_pending || info_i.halt_req) begin
      sleep_d = 1'b0;
    end
    if (take_entry) begin
      sleep_d = 1'b0;
    end
  end

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      debug_mode_q   <= 1'b0;
      sleep_q        <= 1'b0;
      last_npc_q     <= cfg_i.boot_addr;
      entry_valid_q  <= 1'b0;
      exit_valid_q   <= 1'b0;
      illegal_dret_q <= 1'b0;
    end else begin
      sleep_q        <= sleep_d;
      entry_valid_q  <= take_entry;
      exit_valid_q   <= take_exit;
      illegal_dret_q <= bad_dret;

      if (take_entry) begin
        debug_mode_q <= 1'b1;
      end else if (take_exit) begin
        debug_mode_q <= 1'b0;
      end

      // Program flow resumes at dpc after dret
      if (take_exit) begin
        last_npc_q <= dpc_q;
      end else if (info_i.valid && !debug_mode_q) begin
        last_npc_q <= info_i.next_pc;
      end
    end
  end

  // --------------------------------------------------
  // Payload registers
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (take_entry) begin
      dpc_q              <= dpc_d;
      entry_q.cause      <= cause;
      entry_q.dpc        <= dpc_d;
      entry_q.handler_pc <= handler_pc;
    end
    if (take_exit) begin
      resume_pc_q <= dpc_q;
    end
  end

  assign entry_valid_o  = entry_valid_q;
  assign entry_o        = entry_q;
  assign exit_valid_o   = exit_valid_q;
  assign resume_pc_o    = resume_pc_q;
  assign illegal_dret_o = illegal_dret_q;
  assign debug_mode_o   = debug_mode_q;
  assign sleep_o        = sleep_q;

endmodule

// File: debug_monitor_top.sv
`timescale 1ns/1ps

module debug_monitor_top (
  input  logic                           cov_assert_if,
  input  logic                           rst_n_i,
  input  debug_mon_pkg::retire_t         retire_i,
  input  logic                           debug_req_i,
  input  logic [debug_mon_pkg::XLEN-1:0] irq_i,
  input  logic [debug_mon_pkg::XLEN-1:0] mie_i,
  input  debug_mon_pkg::dbg_cfg_t        cfg_i,
  output logic                           entry_valid_o,
  output debug_mon_pkg::dbg_entry_t      entry_o,
  output logic                           exit_valid_o,
  output logic [debug_mon_pkg::XLEN-1:0] resume_pc_o,
  output logic                           illegal_dret_o,
  output logic                           debug_mode_o,
  output logic                           sleep_o
);

  // Registered stage 1 result
  debug_mon_pkg::cycle_info_t info;

  // --------------------------------------------------
  // Stage 1, classify retire and sample requests
  // --------------------------------------------------
  insn_classifier u_classifier (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .retire_i      (retire_i),
    .debug_req_i   (debug_req_i),
    .irq_i         (irq_i),
    .mie_i         (mie_i),
    .cfg_i         (cfg_i),
    .info_o        (info)
  );

  // --------------------------------------------------
  // Stage 2, debug state and output strobes
  // --------------------------------------------------
  debug_cause_arbiter u_arbiter (
    .cov_assert_if  (cov_assert_if),
    .rst_n_i        (rst_n_i),
    .info_i         (info),
    .cfg_i          (cfg_i),
    .entry_valid_o  (entry_valid_o),
    .entry_o        (entry_o),
    .exit_valid_o   (exit_valid_o),
    .resume_pc_o    (resume_pc_o),
    .illegal_dret_o (illegal_dret_o),
    .debug_mode_o   (debug_mode_o),
    .sleep_o        (sleep_o)
  );

endmodule

// File: debug_monitor_checker.sv
`timescale 1ns/1ps

module debug_monitor_checker (
  input logic                      cov_assert_if,
  input logic                      rst_n_i,
  input logic                      entry_valid_o,
  input debug_mon_pkg::dbg_entry_t entry_o,
  input logic                      exit_valid_o,
  input logic                      debug_mode_o,
  input logic                      sleep_o
);

  // Failed assertion count, read by the testbench at the end
  int fail_cnt = 0;

  // --------------------------------------------------
  // Mode rules
  // --------------------------------------------------

  // A halted core cannot be asleep
  sleep_not_in_debug: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    !(sleep_o && debug_mode_o)
  ) else begin
    fail_cnt++;
    $error("sleep_o and debug_mode_o high together");
  end

  // Exit strobe follows a cycle spent in debug mode
  exit_from_debug: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    exit_valid_o |-> $past(debug_mode_o)
  ) else begin
    fail_cnt++;
    $error("exit_valid_o without debug mode");
  end

  // Handler entry is word aligned
  handler_aligned: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    entry_valid_o |-> (entry_o.handler_pc[1:0] == 2'b00)
  ) else begin
    fail_cnt++;
    $error("handler_pc not word aligned");
  end

endmodule

bind debug_monitor_top debug_monitor_checker u_checker (
  .cov_assert_if (cov_assert_if),
  .rst_n_i       (rst_n_i),
  .entry_valid_o (entry_valid_o),
  .entry_o       (entry_o),
  .exit_valid_o  (exit_valid_o),
  .debug_mode_o  (debug_mode_o),
  .sleep_o       (sleep_o)
);

// File: tb_debug_monitor.sv
`timescale 1ns/1ps

module tb_debug_monitor;

  localparam int XLEN            = debug_mon_pkg::XLEN;
  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 2;
  localparam int DIRECTED_CYCLES = 90;
  localparam int RANDOM_CYCLES   = 400;
  localparam int DRAIN_CYCLES    = 4;
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES +
                                   DRAIN_CYCLES + 50;

  localparam logic [XLEN-1:0] NOP_INSN   = 32'h0000_0013;
  localparam logic [XLEN-1:0] CNOP_INSN  = 32'h0000_0001;
  localparam logic [XLEN-1:0] CEBRK_WORD = {16'h1234, debug_mon_pkg::CEBREAK_INSN};
  localparam logic [XLEN-1:0] TRIG_PC    = 32'h0000_0100;
  localparam logic [XLEN-1:0] DBG_PC     = 32'h0000_0800;

  // Reference model state
  typedef struct packed {
    logic            debug_mode;
    logic            sleep;
    logic [XLEN-1:0] dpc;
    logic [XLEN-1:0] last_npc;
  } model_t;

  typedef struct packed {
    logic                      entry_valid;
    debug_mon_pkg::dbg_entry_t entry;
    logic                      exit_valid;
    logic [XLEN-1:0]           resume_pc;
    logic                      illegal_dret;
    logic                      debug_mode;
    logic                      sleep;
  } expect_t;

  typedef struct packed {
    model_t  state;
    expect_t outs;
  } step_t;

  logic                      cov_assert_if;
  logic                      rst_n_i;
  debug_mon_pkg::retire_t    retire_i;
  logic                      debug_req_i;
  logic [XLEN-1:0]           irq_i;
  logic [XLEN-1:0]           mie_i;
  debug_mon_pkg::dbg_cfg_t   cfg_i;
  logic                      entry_valid_o;
  debug_mon_pkg::dbg_entry_t entry_o;
  logic                      exit_valid_o;
  logic [XLEN-1:0]           resume_pc_o;
  logic                      illegal_dret_o;
  logic                      debug_mode_o;
  logic                      sleep_o;

  model_t  mstate;
  expect_t exp_q[$];
  integer  seed;
  int      check_cnt = 0;
  int      error_cnt = 0;
  int      cycle_cnt = 0;

  debug_monitor_top u_dut (
    .cov_assert_if  (cov_assert_if),
    .rst_n_i        (rst_n_i),
    .retire_i       (retire_i),
    .debug_req_i    (debug_req_i),
    .irq_i          (irq_i),
    .mie_i          (mie_i),
    .cfg_i          (cfg_i),
    .entry_valid_o  (entry_valid_o),
    .entry_o        (entry_o),
    .exit_valid_o   (exit_valid_o),
    .resume_pc_o    (resume_pc_o),
    .illegal_dret_o (illegal_dret_o),
    .debug_mode_o   (debug_mode_o),
    .sleep_o        (sleep_o)
  );

  initial begin
    cov_assert_if = 1'b0;
    forever #(CLK_PERIOD / 2) cov_assert_if = ~cov_assert_if;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic step_t reference_step(
    input debug_mon_pkg::retire_t  rt,
    input logic                    req,
    input logic [XLEN-1:0]         irq,
    input logic [XLEN-1:0]         mie,
    input debug_mon_pkg::dbg_cfg_t cfg,
    input model_t                  cur
  );
    step_t                     res;
    logic                      rvc;
    logic [XLEN-1:0]           npc;
    logic                      ebrk;
    logic                      wfi;
    logic                      dret;
    logic                      trig;
    debug_mon_pkg::dbg_cause_t cause;
    logic [XLEN-1:0]           dpc;

    rvc  = (rt.insn[1:0] != 2'b11);
    npc  = rvc ? rt.pc + 32'd2 : rt.pc + 32'd4;
    ebrk = rt.valid && ((rt.insn == debug_mon_pkg::EBREAK_INSN) ||
                        (rvc && (rt.insn[15:0] == debug_mon_pkg::CEBREAK_INSN)));
    wfi  = rt.valid && (rt.insn == debug_mon_pkg::WFI_INSN);
    dret = rt.valid && (rt.insn == debug_mon_pkg::DRET_INSN);
    trig = rt.valid && cfg.trig_en && (rt.pc == cfg.tdata2);

    // Trigger, then ebreak, then halt request, then single step
    cause = debug_mon_pkg::CAUSE_NONE;
    dpc   = cur.dpc;
    if (!cur.debug_mode) begin
      if (trig) begin
        cause = debug_mon_pkg::CAUSE_TRIGGER;
        dpc   = rt.pc;
      end else if (ebrk && cfg.ebreakm) begin
        cause = debug_mon_pkg::CAUSE_EBREAK;
        dpc   = rt.pc;
      end else if (req) begin
        cause = debug_mon_pkg::CAUSE_HALTREQ;
        dpc   = rt.valid ? npc : cur.last_npc;
      end else if (rt.valid && cfg.step) begin
        cause = debug_mon_pkg::CAUSE_STEP;
        dpc   = npc;
      end
    end

    res                       = '0;
    res.state                 = cur;
    res.outs.entry_valid      = (cause != debug_mon_pkg::CAUSE_NONE);
    res.outs.entry.cause      = cause;
    res.outs.entry.dpc        = dpc;
    res.outs.entry.handler_pc = {cfg.halt_addr[XLEN-1:2], 2'b00};
    res.outs.exit_valid       = cur.debug_mode && dret;
    res.outs.resume_pc        = cur.dpc;
    res.outs.illegal_dret     = !cur.debug_mode && dret && !res.outs.entry_valid;

    if (wfi && !cur.debug_mode && !req && !cfg.step) begin
      res.state.sleep = 1'b1;
    end
    if ((|(irq & mie)) || req || res.outs.entry_valid) begin
      res.state.sleep = 1'b0;
    end

    if (res.outs.entry_valid) begin
      res.state.debug_mode = 1'b1;
      res.state.dpc        = dpc;
    end else if (res.outs.exit_valid) begin
      res.state.debug_mode = 1'b0;
    end
    if (res.outs.exit_valid) begin
      res.state.last_npc = cur.dpc;
    end else if (rt.valid && !cur.debug_mode) begin
      res.state.last_npc = npc;
    end

    res.outs.debug_mode = res.state.debug_mode;
    res.outs.sleep      = res.state.sleep;
    return res;
  endfunction

  // --------------------------------------------------
  // Compare tasks and process
  // --------------------------------------------------
  task automatic compare_entry(input debug_mon_pkg::dbg_entry_t got,
                               input debug_mon_pkg::dbg_entry_t exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("** Error: entry_o got %h expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic compare_pc(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Outputs trail the sampled inputs by two edges
  always @(negedge cov_assert_if) begin : compare_proc
    step_t   nxt;
    expect_t exp;
    if (!rst_n_i) begin
      mstate.debug_mode = 1'b0;
      mstate.sleep      = 1'b0;
      mstate.dpc        = '0;
      mstate.last_npc   = cfg_i.boot_addr;
      exp_q.delete();
    end else begin
      if (exp_q.size() >= 2) begin
        exp = exp_q.pop_front();
        compare_flag("entry_valid_o", entry_valid_o, exp.entry_valid);
        if (exp.entry_valid) begin
          compare_entry(entry_o, exp.entry);
        end
        compare_flag("exit_valid_o", exit_valid_o, exp.exit_valid);
        if (exp.exit_valid) begin
          compare_pc("resume_pc_o", resume_pc_o, exp.resume_pc);
        end
        compare_flag("illegal_dret_o", illegal_dret_o, exp.illegal_dret);
        compare_flag("debug_mode_o", debug_mode_o, exp.debug_mode);
        compare_flag("sleep_o", sleep_o, exp.sleep);
      end
      nxt    = reference_step(retire_i, debug_req_i, irq_i, mie_i, cfg_i, mstate);
      mstate = nxt.state;
      exp_q.push_back(nxt.outs);
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  function automatic debug_mon_pkg::dbg_cfg_t debug_cfg(input logic ebreakm, input logic step);
    debug_mon_pkg::dbg_cfg_t c;
    c.ebreakm   = ebreakm;
    c.step      = step;
    c.trig_en   = 1'b1;
    c.tdata2    = TRIG_PC;
    c.halt_addr = 32'h0000_0803;
    c.boot_addr = 32'h0000_0080;
    return c;
  endfunction

  task automatic drive_cycle(input logic valid, input logic [XLEN-1:0] pc,
                             input logic [XLEN-1:0] insn, input logic req,
                             input logic [XLEN-1:0] irq);
    debug_mon_pkg::retire_t rt;
    rt.valid = valid;
    rt.pc    = pc;
    rt.insn  = insn;
    @(posedge cov_assert_if);
    retire_i    <= rt;
    debug_req_i <= req;
    irq_i       <= irq;
  endtask

  task automatic retire(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] insn);
    drive_cycle(1'b1, pc, insn, 1'b0, '0);
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, '0, '0, 1'b0, '0);
  endtask

  // Quiet cycles on both sides keep both stages on one configuration
  task automatic apply_cfg(input debug_mon_pkg::dbg_cfg_t c);
    idle(2);
    @(posedge cov_assert_if);
    cfg_i <= c;
    idle(2);
  endtask

  task automatic random_cycle();
    logic [31:0]     r;
    logic [XLEN-1:0] insn;
    logic [XLEN-1:0] irq;
    r = $random(seed);
    case (r[4:2])
      3'd0, 3'd1: insn = NOP_INSN;
      3'd2:       insn = CNOP_INSN;
      3'd3:       insn = debug_mon_pkg::EBREAK_INSN;
      3'd4:       insn = CEBRK_WORD;
      3'd5:       insn = debug_mon_pkg::WFI_INSN;
      default:    insn = debug_mon_pkg::DRET_INSN;
    endcase
    irq = (r[15:12] == 4'h0) ? {28'h0, r[11:8]} : '0;
    drive_cycle(r[0] | r[1], TRIG_PC + {24'h0, r[21:16], 2'b00}, insn,
                r[26:22] == 5'd0, irq);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    seed        = 54088;
    rst_n_i     <= 1'b0;
    retire_i    <= '0;
    debug_req_i <= 1'b0;
    irq_i       <= '0;
    mie_i       <= 32'h0000_0888;
    cfg_i       <= debug_cfg(1'b1, 1'b0);
    repeat (RESET_CYCLES) @(posedge cov_assert_if);
    rst_n_i <= 1'b1;
    idle(2);

    // Trigger wins over a halt request in the same cycle
    drive_cycle(1'b1, TRIG_PC, NOP_INSN, 1'b1, '0);
    idle(2);
    retire(DBG_PC, debug_mon_pkg::DRET_INSN);
    idle(2);

    // ebreak and c.ebreak with ebreakm set and then cleared
    retire(32'h200, debug_mon_pkg::EBREAK_INSN);
    retire(DBG_PC, debug_mon_pkg::DRET_INSN);
    retire(32'h204, CEBRK_WORD);
    retire(DBG_PC, debug_mon_pkg::DRET_INSN);
    apply_cfg(debug_cfg(1'b0, 1'b0));
    retire(32'h208, debug_mon_pkg::EBREAK_INSN);
    retire(32'h20C, CEBRK_WORD);
    idle(2);
    // Halt request with no retire uses the last next pc
    drive_cycle(1'b0, '0, '0, 1'b1, '0);
    idle(2);
    retire(DBG_PC, debug_mon_pkg::DRET_INSN);

    // Single step over 32-bit and compressed words
    apply_cfg(debug_cfg(1'b1, 1'b1));
    retire(32'h300, NOP_INSN);
    retire(DBG_PC, debug_mon_pkg::DRET_INSN);
    retire(32'h304, CNOP_INSN);
    retire(DBG_PC, debug_mon_pkg::DRET_INSN);

    // dret outside debug mode
    apply_cfg(debug_cfg(1'b1, 1'b0));
    retire(32'h310, debug_mon_pkg::DRET_INSN);
    idle(2);

    // WFI sleep with wake on an enabled irq and on a halt request
    retire(32'h320, debug_mon_pkg::WFI_INSN);
    idle(3);
    drive_cycle(1'b0, '0, '0, 1'b0, 32'h0000_0001);
    drive_cycle(1'b0, '0, '0, 1'b0, 32'h0000_0008);
    idle(2);
    retire(32'h324, debug_mon_pkg::WFI_INSN);
    idle(2);
    drive_cycle(1'b0, '0, '0, 1'b1, '0);
    idle(2);
    retire(DBG_PC, debug_mon_pkg::WFI_INSN);
    retire(DBG_PC, debug_mon_pkg::DRET_INSN);
    idle(2);

    // Mixed random traffic without and with single step
    repeat (RANDOM_CYCLES / 2) random_cycle();
    apply_cfg(debug_cfg(1'b1, 1'b1));
    repeat (RANDOM_CYCLES / 2) random_cycle();

    idle(DRAIN_CYCLES);
    #(CLK_PERIOD / 4);
    $display("checks %0d, value errors %0d, assertion failures %0d",
             check_cnt, error_cnt, u_dut.u_checker.fail_cnt);
    if ((error_cnt == 0) && (u_dut.u_checker.fail_cnt == 0)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  always @(posedge cov_assert_if) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("checks %0d, value errors %0d, assertion failures %0d",
             check_cnt, error_cnt, u_dut.u_checker.fail_cnt);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: sources.f
debug_mon_pkg.sv
insn_classifier.sv
debug_cause_arbiter.sv
debug_monitor_top.sv
debug_monitor_checker.sv
tb_debug_monitor.sv

// File: Makefile
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f sources.f \
	  --top-module tb_debug_monitor --Mdir $(OBJ_DIR) -o tb_debug_monitor
	./$(OBJ_DIR)/tb_debug_monitor | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
